// ==== logic/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

    // ************************************************************
    // Tile sizing
    // ************************************************************
    localparam int NUM_LINKS     = 2;
    localparam int NUM_PORTS     = NUM_LINKS + 1;  // Port 0 is the local endpoint.
    localparam int FIFO_DEPTH    = 4;
    localparam int CLKS_PER_BIT  = 16;

    localparam int NODE_ID_W     = 4;
    localparam int ROUTE_ENTRIES = 2 ** NODE_ID_W;
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam int BIT_CNT_W     = $clog2(CLKS_PER_BIT);

    typedef logic [NODE_ID_W-1:0]  node_id_t;
    typedef logic [1:0]            port_t;
    typedef logic [7:0]            byte_t;
    typedef logic [4:0]            bus_addr_t;
    typedef logic [15:0]           bus_data_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // One bit wider to hold a full count.
    typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;
    typedef logic [3:0]            event_cnt_t;

    // High byte goes first on the wire.
    typedef struct packed {
        node_id_t dest;
        node_id_t src;
        byte_t    payload;
    } flit_t;

    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        logic      write;
        logic      read;
    } bus_req_t;

    typedef struct packed {
        bus_addr_t addr;
        bus_data_t data;
        logic      write;
    } cfg_write_t;

    // ************************************************************
    // Register map
    // ************************************************************
    localparam bus_addr_t ADDR_NODE_ID    = 5'd0;
    localparam bus_addr_t ADDR_TX         = 5'd1;
    localparam bus_addr_t ADDR_RX         = 5'd2;
    localparam bus_addr_t ADDR_STATUS     = 5'd3;
    localparam bus_addr_t ADDR_ROUTE_BASE = 5'd16;  // Table runs to the top of the map.

endpackage

`default_nettype wire

// ==== logic/flit_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_uart
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rx,
    output logic  tx,
    output flit_t rx_flit,
    output logic  rx_valid,
    output logic  rx_error,
    input  flit_t tx_flit,
    input  logic  tx_start,
    output logic  tx_busy
);
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    tx_state_t  tx_state;
    bit_cnt_t   tx_cnt;
    logic [2:0] tx_bit;
    logic       tx_second;
    logic       tx_tick;
    byte_t      tx_shift;
    byte_t      tx_low;

    rx_state_t  rx_state;
    bit_cnt_t   rx_cnt;
    logic [2:0] rx_bit;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_have_high;
    byte_t      rx_shift;
    byte_t      rx_high;

    // ************************************************************
    // Transmitter
    // ************************************************************
    assign tx_tick = (tx_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));
    assign tx_busy = (tx_state != TX_IDLE);
    assign tx      = (tx_state == TX_START) ? 1'b0 :
                     (tx_state == TX_DATA) ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_state  <= TX_IDLE;
            tx_cnt    <= '0;
            tx_bit    <= '0;
            tx_second <= 1'b0;
        end else if (tx_state == TX_IDLE) begin
            tx_cnt    <= '0;
            tx_second <= 1'b0;
            if (tx_start) begin
                tx_state <= TX_START;
            end
        end else begin
            tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
            if (tx_tick) begin
                case (tx_state)
                    TX_START: begin
                        tx_state <= TX_DATA;
                        tx_bit   <= '0;
                    end
                    TX_DATA: begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) tx_state <= TX_STOP;
                    end
                    default: begin
                        tx_state  <= tx_second ? TX_IDLE : TX_START;  // Low byte follows at once.
                        tx_second <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_state == TX_IDLE && tx_start) begin
            tx_shift <= tx_flit[15:8];
            tx_low   <= tx_flit[7:0];
        end else if (tx_tick && tx_state == TX_DATA) begin
            tx_shift <= {1'b1, tx_shift[7:1]};  // LSB first.
        end else if (tx_tick && tx_state == TX_STOP) begin
            tx_shift <= tx_low;
        end
    end

    // ************************************************************
    // Receiver
    // ************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta      <= 1'b1;
            rx_sync      <= 1'b1;
            rx_state     <= RX_IDLE;
            rx_cnt       <= '0;
            rx_bit       <= '0;
            rx_have_high <= 1'b0;
            rx_valid     <= 1'b0;
            rx_error     <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            rx_cnt   <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync) rx_state <= RX_START;
                end
                RX_START: begin
                    if (rx_cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;  // A short glitch is ignored.
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) rx_state <= RX_STOP;
                    end
                end
                default: begin
                    if (rx_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        rx_state     <= RX_IDLE;
                        rx_have_high <= rx_sync && !rx_have_high;
                        rx_valid     <= rx_sync && rx_have_high;
                        rx_error     <= !rx_sync;  // Drops any half-received flit.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
            if (rx_state == RX_DATA) begin
                rx_shift <= {rx_sync, rx_shift[7:1]};
            end else if (rx_state == RX_STOP && rx_sync) begin
                if (rx_have_high) rx_flit <= {rx_high, rx_shift};
                else rx_high <= rx_shift;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/route_config.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_config
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  cfg_write_t                cfg,
    input  bus_addr_t                 cfg_addr,
    output bus_data_t                 cfg_rdata,
    input  node_id_t [NUM_PORTS-1:0]  route_dest,
    output port_t    [NUM_PORTS-1:0]  route_port
);
    node_id_t node_id;
    port_t    route_table [ROUTE_ENTRIES];

    always_ff @(posedge clk) begin
        if (reset) begin
            node_id <= '0;
            for (int n = 0; n < ROUTE_ENTRIES; n++) begin
                route_table[n] <= '0;
            end
        end else if (cfg.write) begin
            if (cfg.addr == ADDR_NODE_ID) begin
                node_id <= node_id_t'(cfg.data);
            end else if (cfg.addr >= ADDR_ROUTE_BASE) begin
                route_table[node_id_t'(cfg.addr - ADDR_ROUTE_BASE)] <= port_t'(cfg.data);
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        if (cfg_addr == ADDR_NODE_ID) begin
            cfg_rdata = bus_data_t'(node_id);
        end else if (cfg_addr >= ADDR_ROUTE_BASE) begin
            cfg_rdata = bus_data_t'(route_table[node_id_t'(cfg_addr - ADDR_ROUTE_BASE)]);
        end
    end

    // Traffic for this node always goes to the endpoint.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            route_port[p] = (route_dest[p] == node_id) ? port_t'(0) : route_table[route_dest[p]];
        end
    end

endmodule

`default_nettype wire

// ==== logic/route_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_switch
    import noc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  flit_t    [NUM_PORTS-1:0]  in_flit,
    input  logic     [NUM_PORTS-1:0]  in_valid,
    output logic     [NUM_PORTS-1:0]  in_drop,
    output node_id_t [NUM_PORTS-1:0]  route_dest,
    input  port_t    [NUM_PORTS-1:0]  route_port,
    output flit_t    [NUM_PORTS-1:0]  out_flit,
    output logic     [NUM_PORTS-1:0]  out_valid,
    input  logic     [NUM_PORTS-1:0]  out_ready
);
    flit_t                  fifo_mem [NUM_PORTS][FIFO_DEPTH];
    fifo_ptr_t              wr_ptr   [NUM_PORTS];
    fifo_ptr_t              rd_ptr   [NUM_PORTS];
    fifo_cnt_t              count    [NUM_PORTS];
    flit_t [NUM_PORTS-1:0]  head;
    logic  [NUM_PORTS-1:0]  push;
    logic  [NUM_PORTS-1:0]  pop;
    logic  [NUM_PORTS-1:0]  grant_any;
    port_t                  grant_src [NUM_PORTS];
    port_t                  rr_last   [NUM_PORTS];

    // ************************************************************
    // Input FIFOs
    // ************************************************************
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            head[i]       = fifo_mem[i][rd_ptr[i]];
            route_dest[i] = head[i].dest;
            push[i]       = in_valid[i] && (count[i] != FIFO_DEPTH);
            in_drop[i]    = in_valid[i] && (count[i] == FIFO_DEPTH);  // No credits, so drop.
        end
    end

    // ************************************************************
    // Round-robin arbitration per output
    // ************************************************************
    always_comb begin
        int idx;
        pop       = '0;
        grant_any = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            grant_src[o] = rr_last[o];
            // Search starts just past the last winner.
            for (int k = 1; k <= NUM_PORTS; k++) begin
                idx = rr_last[o] + k;
                if (idx >= NUM_PORTS) idx = idx - NUM_PORTS;
                if (!grant_any[o] && out_ready[o] && !out_valid[o] &&
                    count[idx] != 0 && route_port[idx] == o) begin
                    grant_any[o] = 1'b1;
                    grant_src[o] = port_t'(idx);
                    pop[idx]     = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (push[i]) fifo_mem[i][wr_ptr[i]] <= in_flit[i];
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (grant_any[o]) out_flit[o] <= head[grant_src[o]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                wr_ptr[i]  <= '0;
                rd_ptr[i]  <= '0;
                count[i]   <= '0;
                rr_last[i] <= '0;
            end
        end else begin
            out_valid <= grant_any;  // A grant also blocks the next cycle on that output.
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (push[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
                if (pop[i]) rd_ptr[i] <= rd_ptr[i] + 1'b1;
                count[i] <= count[i] + fifo_cnt_t'(push[i]) - fifo_cnt_t'(pop[i]);
                if (grant_any[i]) rr_last[i] <= grant_src[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tile_endpoint.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_endpoint
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  bus_req_t              bus_req,
    output bus_data_t             bus_rdata,
    output cfg_write_t            cfg,
    input  bus_data_t             cfg_rdata,
    output flit_t                 tx_flit,
    output logic                  tx_valid,
    input  flit_t                 rx_flit,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    input  logic [NUM_PORTS-1:0]  link_drop,
    input  logic [NUM_LINKS-1:0]  link_error,
    output logic                  packet_recv
);
    node_id_t   node_id;
    logic       tx_pending;
    flit_t      wr_flit;
    flit_t      rx_mem [FIFO_DEPTH];
    fifo_ptr_t  rx_wr_ptr;
    fifo_ptr_t  rx_rd_ptr;
    fifo_cnt_t  rx_count;
    event_cnt_t drop_cnt;
    event_cnt_t err_cnt;
    logic       is_cfg;
    logic       tx_write;
    logic       rx_push;
    logic       rx_pop;

    // ************************************************************
    // Bus decode
    // ************************************************************
    assign is_cfg   = (bus_req.addr == ADDR_NODE_ID) || (bus_req.addr >= ADDR_ROUTE_BASE);
    assign cfg      = '{addr: bus_req.addr, data: bus_req.wdata,
                        write: bus_req.write && is_cfg};
    assign wr_flit  = flit_t'(bus_req.wdata);
    assign tx_write = bus_req.write && (bus_req.addr == ADDR_TX) && !tx_pending;
    assign tx_valid = tx_pending;  // Held until port 0 has room.
    assign rx_push  = rx_valid && (rx_count != FIFO_DEPTH);
    assign rx_pop   = bus_req.read && (bus_req.addr == ADDR_RX) && (rx_count != 0);
    assign rx_ready = (rx_count <= FIFO_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (tx_write) tx_flit <= '{dest: wr_flit.dest, src: node_id, payload: wr_flit.payload};
        if (rx_push) rx_mem[rx_wr_ptr] <= rx_flit;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            node_id     <= '0;
            tx_pending  <= 1'b0;
            rx_wr_ptr   <= '0;
            rx_rd_ptr   <= '0;
            rx_count    <= '0;
            drop_cnt    <= '0;
            err_cnt     <= '0;
            packet_recv <= 1'b0;
            bus_rdata   <= '0;
        end else begin
            if (cfg.write && bus_req.addr == ADDR_NODE_ID) node_id <= node_id_t'(bus_req.wdata);
            if (tx_write) tx_pending <= 1'b1;
            else if (tx_pending && !link_drop[0]) tx_pending <= 1'b0;
            if (rx_push) rx_wr_ptr <= rx_wr_ptr + 1'b1;
            if (rx_pop) rx_rd_ptr <= rx_rd_ptr + 1'b1;
            rx_count    <= rx_count + fifo_cnt_t'(rx_push) - fifo_cnt_t'(rx_pop);
            packet_recv <= rx_push;
            // Both counters saturate.
            if (|link_drop[NUM_PORTS-1:1] && drop_cnt != '1) drop_cnt <= drop_cnt + 1'b1;
            if (|link_error && err_cnt != '1) err_cnt <= err_cnt + 1'b1;
            if (bus_req.read) begin
                case (bus_req.addr)
                    ADDR_RX:     bus_rdata <= rx_pop ? bus_data_t'(rx_mem[rx_rd_ptr]) : '0;
                    ADDR_STATUS: bus_rdata <= {3'b000, tx_pending, err_cnt, drop_cnt,
                                               1'b0, rx_count};
                    default:     bus_rdata <= is_cfg ? cfg_rdata : '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_LINKS-1:0]  uart_rx,
    output wire  [NUM_LINKS-1:0]  uart_tx,
    input  bus_req_t              bus_req,
    output bus_data_t             bus_rdata,
    output logic                  packet_recv
);
    wire flit_t    [NUM_PORTS-1:0] in_flit;
    wire logic     [NUM_PORTS-1:0] in_valid;
    wire logic     [NUM_PORTS-1:0] in_drop;
    wire node_id_t [NUM_PORTS-1:0] route_dest;
    wire port_t    [NUM_PORTS-1:0] route_port;
    wire flit_t    [NUM_PORTS-1:0] out_flit;
    wire logic     [NUM_PORTS-1:0] out_valid;
    wire logic     [NUM_LINKS-1:0] tx_busy;
    wire logic     [NUM_LINKS-1:0] rx_error;
    wire cfg_write_t               cfg;
    wire bus_data_t                cfg_rdata;
    wire logic                     rx_ready;

    // Link i sits on switch port i + 1.
    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        flit_uart link_uart (
            .clk      (clk),
            .reset    (reset),
            .rx       (uart_rx[i]),
            .tx       (uart_tx[i]),
            .rx_flit  (in_flit[i+1]),
            .rx_valid (in_valid[i+1]),
            .rx_error (rx_error[i]),
            .tx_flit  (out_flit[i+1]),
            .tx_start (out_valid[i+1]),
            .tx_busy  (tx_busy[i])
        );
    end

    route_config config_regs (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .cfg_addr   (bus_req.addr),
        .cfg_rdata  (cfg_rdata),
        .route_dest (route_dest),
        .route_port (route_port)
    );

    route_switch switch_core (
        .clk        (clk),
        .reset      (reset),
        .in_flit    (in_flit),
        .in_valid   (in_valid),
        .in_drop    (in_drop),
        .route_dest (route_dest),
        .route_port (route_port),
        .out_flit   (out_flit),
        .out_valid  (out_valid),
        .out_ready  ({~tx_busy, rx_ready})
    );

    tile_endpoint endpoint (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .cfg         (cfg),
        .cfg_rdata   (cfg_rdata),
        .tx_flit     (in_flit[0]),
        .tx_valid    (in_valid[0]),
        .rx_flit     (out_flit[0]),
        .rx_valid    (out_valid[0]),
        .rx_ready    (rx_ready),
        .link_drop   (in_drop),
        .link_error  (rx_error),
        .packet_recv (packet_recv)
    );

endmodule

`default_nettype wire

// ==== tb/tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_tb
    import noc_pkg::*;
();
    localparam int       SRC_COUNT  = 3;  // Bus, link 0 and link 1.
    localparam node_id_t MY_NODE    = 4'h5;
    localparam node_id_t LINK0_SRC  = 4'h9;
    localparam node_id_t LINK1_SRC  = 4'ha;
    localparam int       WAIT_LIMIT = 20000;

    logic                 clk;
    logic                 reset;
    logic [NUM_LINKS-1:0] uart_rx;
    wire  [NUM_LINKS-1:0] uart_tx;
    bus_req_t             bus_req;
    bus_data_t            bus_rdata;
    logic                 packet_recv;

    integer    seed;
    int        errors;
    int        timeouts;
    int        recv_pulses;
    int        exp_pulses;
    int        links_busy;
    port_t     route_tbl [ROUTE_ENTRIES];
    flit_t     exp_q [NUM_PORTS*SRC_COUNT][$];  // One queue per output and source.
    bus_data_t rd;

    tile UUT (
        .clk         (clk),
        .reset       (reset),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx),
        .bus_req     (bus_req),
        .bus_rdata   (bus_rdata),
        .packet_recv (packet_recv)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!reset && packet_recv === 1'b1) recv_pulses++;
    end

    // ************************************************************
    // Scoreboard
    // ************************************************************
    function automatic int src_index(node_id_t src);
        if (src == MY_NODE) return 0;
        if (src == LINK0_SRC) return 1;
        if (src == LINK1_SRC) return 2;
        return -1;
    endfunction

    function automatic int out_port(node_id_t dest);
        return (dest == MY_NODE) ? 0 : int'(route_tbl[dest]);  // Own node beats the table.
    endfunction

    function automatic int pending_flits();
        int total = 0;
        foreach (exp_q[k]) total += exp_q[k].size();
        return total;
    endfunction

    task automatic check_equal(string name, logic [15:0] exp, logic [15:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_flit(flit_t f);
        int p;
        p = out_port(f.dest);
        exp_q[p * SRC_COUNT + src_index(f.src)].push_back(f);
        if (p == 0) exp_pulses++;
    endtask

    task automatic check_delivery(int p, flit_t f, string name);
        int s;
        flit_t e;
        s = src_index(f.src);
        if (s < 0 || exp_q[p * SRC_COUNT + s].size() == 0) begin
            $display("Unexpected flit %h came out of switch port %0d", f, p);
            errors++;
        end else begin
            e = exp_q[p * SRC_COUNT + s].pop_front();
            check_equal(name, e, f);
        end
    endtask

    // ************************************************************
    // Bus side
    // ************************************************************
    task automatic bus_write(bus_addr_t addr, bus_data_t data);
        @(posedge clk);
        bus_req <= '{addr: addr, wdata: data, write: 1'b1, read: 1'b0};
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic bus_read(bus_addr_t addr, output bus_data_t data);
        @(posedge clk);
        bus_req <= '{addr: addr, wdata: '0, write: 1'b0, read: 1'b1};
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        data = bus_rdata;  // Registered in the cycle after the strobe.
    endtask

    task automatic service_rx(output bus_data_t st);
        bus_data_t data;
        bus_read(ADDR_STATUS, st);
        if (st[2:0] != 3'd0) begin
            bus_read(ADDR_RX, data);
            check_delivery(0, flit_t'(data), "bus_rdata");
        end
    endtask

    task automatic bus_send(node_id_t dest, byte_t payload);
        bus_data_t st;
        int n;
        n = 0;
        service_rx(st);
        while (st[12] && n < WAIT_LIMIT) begin
            service_rx(st);
            n++;
        end
        if (st[12]) begin
            $display("Timeout: the transmit register never became free");
            timeouts++;
        end
        expect_flit('{dest: dest, src: MY_NODE, payload: payload});
        bus_write(ADDR_TX, {dest, 4'h0, payload});
    endtask

    task automatic wait_drained(string what);
        bus_data_t st;
        int n;
        n = 0;
        while (pending_flits() != 0 && n < WAIT_LIMIT) begin
            service_rx(st);
            n++;
        end
        if (pending_flits() != 0) begin
            $display("Timeout: %0d flits of the %s test never arrived", pending_flits(), what);
            timeouts++;
        end
    endtask

    // ************************************************************
    // Remote UART side
    // ************************************************************
    task automatic drive_bit(int link, logic value);
        @(posedge clk);
        if (link == 0) uart_rx[0] <= value;
        else uart_rx[1] <= value;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic uart_send_byte(int link, byte_t data, logic stop);
        drive_bit(link, 1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(link, data[i]);
        end
        drive_bit(link, stop);  // A low stop bit is a framing error.
    endtask

    task automatic link_send(int link, node_id_t dest);
        flit_t f;
        f = '{dest: dest, src: (link == 0) ? LINK0_SRC : LINK1_SRC,
              payload: byte_t'($random(seed))};
        expect_flit(f);
        uart_send_byte(link, f[15:8], 1'b1);
        uart_send_byte(link, f[7:0], 1'b1);
    endtask

    task automatic uart_recv_byte(int link, output byte_t data);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        check_equal($sformatf("uart_tx[%0d] start bit", link), 16'h0, 16'(uart_tx[link]));
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = uart_tx[link];
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_equal($sformatf("uart_tx[%0d] stop bit", link), 16'h1, 16'(uart_tx[link]));
    endtask

    task automatic watch_link(int link);
        byte_t high;
        byte_t low;
        int n;
        forever begin
            @(negedge clk);
            if (!reset && uart_tx[link] === 1'b0) begin
                uart_recv_byte(link, high);
                n = 0;
                while (uart_tx[link] !== 1'b0 && n < 2 * CLKS_PER_BIT) begin
                    @(negedge clk);
                    n++;
                end
                if (uart_tx[link] !== 1'b0) begin
                    $display("Timeout: low byte never started on uart_tx[%0d]", link);
                    timeouts++;
                end
                uart_recv_byte(link, low);
                check_delivery(link + 1, {high, low}, $sformatf("uart_tx[%0d]", link));
            end
        end
    endtask

    initial begin
        fork
            watch_link(0);
            watch_link(1);
        join
    end

    task automatic link_traffic(int link, int count);
        for (int n = 0; n < count; n++) begin
            link_send(link, node_id_t'($random(seed)));
            repeat (20) drive_bit(link, 1'b1);  // Idle gap keeps the input FIFO shallow.
        end
        links_busy--;
    endtask

    task automatic bus_traffic(int count);
        bus_data_t st;
        int n;
        for (int i = 0; i < count; i++) begin
            bus_send(node_id_t'($random(seed)), byte_t'($random(seed)));
        end
        n = 0;
        while (links_busy != 0 && n < WAIT_LIMIT) begin
            service_rx(st);  // Keeps port 0 flowing while the links still send.
            n++;
        end
        if (links_busy != 0) begin
            $display("Timeout: link traffic did not finish");
            timeouts++;
        end
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        seed        = 32'ha13d_4912;
        errors      = 0;
        timeouts    = 0;
        recv_pulses = 0;
        exp_pulses  = 0;
        links_busy  = 0;
        reset   <= 1'b1;
        uart_rx <= '1;
        bus_req <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        bus_read(ADDR_STATUS, rd);
        check_equal("bus_rdata", 16'h0000, rd);
        check_equal("uart_tx", 16'h0003, 16'(uart_tx));
        bus_write(ADDR_NODE_ID, bus_data_t'(MY_NODE));
        bus_read(ADDR_NODE_ID, rd);
        check_equal("bus_rdata", bus_data_t'(MY_NODE), rd);
        for (int d = 0; d < ROUTE_ENTRIES; d++) begin
            route_tbl[d] = port_t'(d % NUM_PORTS);
            bus_write(ADDR_ROUTE_BASE + bus_addr_t'(d), bus_data_t'(route_tbl[d]));
        end
        for (int d = 0; d < ROUTE_ENTRIES; d++) begin
            bus_read(ADDR_ROUTE_BASE + bus_addr_t'(d), rd);
            check_equal("bus_rdata", bus_data_t'(route_tbl[d]), rd);
        end

        bus_send(MY_NODE, byte_t'($random(seed)));  // Loopback to the own node.
        wait_drained("loopback");
        check_equal("packet_recv", 16'(exp_pulses), 16'(recv_pulses));
        bus_read(ADDR_STATUS, rd);
        check_equal("bus_rdata", 16'h0, 16'(rd[2:0]));

        bus_send(4'd1, byte_t'($random(seed)));
        bus_send(4'd2, byte_t'($random(seed)));
        bus_send(4'd4, byte_t'($random(seed)));
        bus_send(4'd8, byte_t'($random(seed)));
        wait_drained("link transmit");

        link_send(0, MY_NODE);
        link_send(0, 4'd11);  // Passes through to link 1.
        wait_drained("link receive");
        check_equal("packet_recv", 16'(exp_pulses), 16'(recv_pulses));

        uart_send_byte(1, byte_t'($random(seed)), 1'b0);
        repeat (2) drive_bit(1, 1'b1);
        link_send(1, MY_NODE);
        wait_drained("framing error");
        bus_read(ADDR_STATUS, rd);
        check_equal("bus_rdata", 16'h1, 16'(rd[11:8]));

        links_busy = NUM_LINKS;
        fork
            link_traffic(0, 7);
            link_traffic(1, 6);
            bus_traffic(7);
        join
        wait_drained("random traffic");
        check_equal("packet_recv", 16'(exp_pulses), 16'(recv_pulses));
        bus_read(ADDR_STATUS, rd);
        check_equal("bus_rdata", 16'h0100, rd);  // One framing error and nothing else.

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/noc_pkg.sv
logic/flit_uart.sv
logic/route_config.sv
logic/route_switch.sv
logic/tile_endpoint.sv
logic/tile.sv
tb/tile_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tile_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
